// ==== rtl/packet_fifo_pkg.sv ====
package packet_fifo_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int data_width   = 16;
    localparam int slot_words   = 256;
    localparam int slot_count   = 4;
    localparam int offset_width = 8;
    localparam int slot_width   = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One word on the USB data path.
    typedef logic [data_width-1:0] data_t;

    // Word position inside a slot.
    typedef logic [offset_width-1:0] offset_t;

    // Slot index, wraps modulo slot_count.
    typedef logic [slot_width-1:0] slot_t;

    // Closed-slot count, needs one extra bit to reach slot_count itself.
    typedef logic [slot_width:0] count_t;

endpackage

// ==== rtl/packet_write_port.sv ====
`timescale 1ns/1ns

module packet_write_port
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    write_enable,
    input  logic                    pkt_complete,
    output packet_fifo_pkg::slot_t   write_slot,
    output packet_fifo_pkg::offset_t write_offset,
    output logic                    slot_closed
);

    import packet_fifo_pkg::*;

    logic last_word;

    // The open slot is full once the word at the top offset goes in.
    assign last_word = write_enable && (write_offset == offset_t'(slot_words - 1));

    // A short packet ends early on pkt_complete, with or without a word.
    assign slot_closed = last_word || pkt_complete;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            write_slot   <= '0;
            write_offset <= '0;
        end
        else if (slot_closed)
        begin
            write_slot   <= write_slot + slot_t'(1);
            write_offset <= '0;
        end
        else if (write_enable)
        begin
            write_offset <= write_offset + offset_t'(1);
        end
    end

endmodule

// ==== rtl/packet_read_port.sv ====
`timescale 1ns/1ns

module packet_read_port
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    read_enable,
    input  logic                    skip_packet,
    output packet_fifo_pkg::slot_t   read_slot,
    output packet_fifo_pkg::offset_t read_offset,
    output logic                    slot_released
);

    import packet_fifo_pkg::*;

    logic last_word;

    // Reading the top offset drains the slot completely.
    assign last_word = read_enable && (read_offset == offset_t'(slot_words - 1));

    // skip_packet drops whatever is left, the word read with it still counts.
    assign slot_released = last_word || skip_packet;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            read_slot   <= '0;
            read_offset <= '0;
        end
        else if (slot_released)
        begin
            read_slot   <= read_slot + slot_t'(1);
            read_offset <= '0;
        end
        else if (read_enable)
        begin
            read_offset <= read_offset + offset_t'(1);
        end
    end

endmodule

// ==== rtl/packet_slot_tracker.sv ====
`timescale 1ns/1ns

module packet_slot_tracker
(
    input  logic clock,
    input  logic reset,
    input  logic slot_closed,
    input  logic slot_released,
    output logic pkt_waiting,
    output logic have_space
);

    import packet_fifo_pkg::*;

    count_t closed_count;

    // Number of slots that are closed and not yet released.
    // A close and a release in the same cycle cancel out.
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            closed_count <= '0;
        end
        else if (slot_closed && !slot_released)
        begin
            closed_count <= closed_count + count_t'(1);
        end
        else if (slot_released && !slot_closed)
        begin
            closed_count <= closed_count - count_t'(1);
        end
    end

    // Both flags come straight off the registered count.
    assign pkt_waiting = (closed_count != '0);
    assign have_space  = (closed_count < count_t'(slot_count));

endmodule

// ==== rtl/packet_ram.sv ====
`timescale 1ns/1ns

module packet_ram
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    write_enable,
    input  packet_fifo_pkg::slot_t   write_slot,
    input  packet_fifo_pkg::offset_t write_offset,
    input  packet_fifo_pkg::data_t   ram_data_in,
    input  packet_fifo_pkg::slot_t   read_slot,
    input  packet_fifo_pkg::offset_t read_offset,
    output packet_fifo_pkg::data_t   ram_data_out
);

    import packet_fifo_pkg::*;

    localparam int depth = slot_count * slot_words;

    data_t mem [depth];

    logic [slot_width+offset_width-1:0] write_addr;
    logic [slot_width+offset_width-1:0] read_addr;

    // Slot index in the upper bits, word offset below.
    assign write_addr = {write_slot, write_offset};
    assign read_addr  = {read_slot, read_offset};

    always_ff @(posedge clock)
    begin
        if (write_enable)
        begin
            mem[write_addr] <= ram_data_in;
        end
    end

    // The output follows the read pointer one edge behind.
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            ram_data_out <= '0;
        end
        else
        begin
            ram_data_out <= mem[read_addr];
        end
    end

endmodule

// ==== rtl/data_packet_fifo.sv ====
`timescale 1ns/1ns

module data_packet_fifo
(
    input  logic                  clock,
    input  logic                  reset,
    input  packet_fifo_pkg::data_t ram_data_in,
    input  logic                  write_enable,
    input  logic                  pkt_complete,
    input  logic                  read_enable,
    input  logic                  skip_packet,
    output packet_fifo_pkg::data_t ram_data_out,
    output logic                  pkt_waiting,
    output logic                  have_space
);

    import packet_fifo_pkg::*;

    slot_t   write_slot;
    offset_t write_offset;
    logic    slot_closed;

    slot_t   read_slot;
    offset_t read_offset;
    logic    slot_released;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Producer and consumer sides.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    packet_write_port write_port
    (
        .clock        (clock),
        .reset        (reset),
        .write_enable (write_enable),
        .pkt_complete (pkt_complete),
        .write_slot   (write_slot),
        .write_offset (write_offset),
        .slot_closed  (slot_closed)
    );

    packet_read_port read_port
    (
        .clock         (clock),
        .reset         (reset),
        .read_enable   (read_enable),
        .skip_packet   (skip_packet),
        .read_slot     (read_slot),
        .read_offset   (read_offset),
        .slot_released (slot_released)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Status and storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    packet_slot_tracker slot_tracker
    (
        .clock         (clock),
        .reset         (reset),
        .slot_closed   (slot_closed),
        .slot_released (slot_released),
        .pkt_waiting   (pkt_waiting),
        .have_space    (have_space)
    );

    packet_ram ram
    (
        .clock        (clock),
        .reset        (reset),
        .write_enable (write_enable),
        .write_slot   (write_slot),
        .write_offset (write_offset),
        .ram_data_in  (ram_data_in),
        .read_slot    (read_slot),
        .read_offset  (read_offset),
        .ram_data_out (ram_data_out)
    );

endmodule

// ==== dv/tb_data_packet_fifo.sv ====
`timescale 1ns/1ns

module tb_data_packet_fifo;

    import packet_fifo_pkg::*;

    // The tests take roughly 6000 cycles, so this leaves a wide margin.
    localparam int max_cycles = 20000;

    logic  clock;
    logic  reset;
    data_t ram_data_in;
    logic  write_enable;
    logic  pkt_complete;
    logic  read_enable;
    logic  skip_packet;
    data_t ram_data_out;
    logic  pkt_waiting;
    logic  have_space;

    integer seed;
    int     cycle_count = 0;
    int     lengths [$];

    // Shadow model state, updated on the same edges the DUT samples.
    data_t   shadow_mem [slot_count*slot_words];
    slot_t   model_write_slot;
    offset_t model_write_offset;
    slot_t   model_read_slot;
    offset_t model_read_offset;
    int      model_count;
    logic    model_closed;
    logic    model_released;
    logic    read_pending;
    data_t   expected_data;

    data_packet_fifo uut
    (
        .clock        (clock),
        .reset        (reset),
        .ram_data_in  (ram_data_in),
        .write_enable (write_enable),
        .pkt_complete (pkt_complete),
        .read_enable  (read_enable),
        .skip_packet  (skip_packet),
        .ram_data_out (ram_data_out),
        .pkt_waiting  (pkt_waiting),
        .have_space   (have_space)
    );

    always #5 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles.", max_cycles);
            $display("** FAIL **");
            $fatal(1, "Simulation ran out of cycles.");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Value mismatch on %s.", name);
        end
    endtask

    function automatic data_t expected_word(input slot_t slot, input offset_t offset);
        return shadow_mem[{slot, offset}];
    endfunction

    function automatic int short_length();
        return 1 + ($unsigned($random(seed)) % 200);
    endfunction

    function automatic int pick_length();
        if (($random(seed) & 3) == 0)
        begin
            return slot_words;
        end
        return short_length();
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shadow model and compare.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock)
    begin
        if (reset)
        begin
            model_write_slot   = '0;
            model_write_offset = '0;
            model_read_slot    = '0;
            model_read_offset  = '0;
            model_count        = 0;
            read_pending       = 1'b0;
        end
        else
        begin
            // The read sees memory as it was before this edge.
            read_pending = read_enable;
            if (read_enable)
            begin
                expected_data = expected_word(model_read_slot, model_read_offset);
            end
            model_released = (read_enable && model_read_offset == offset_t'(slot_words - 1))
                             || skip_packet;
            model_closed = (write_enable && model_write_offset == offset_t'(slot_words - 1))
                           || pkt_complete;
            if (write_enable)
            begin
                shadow_mem[{model_write_slot, model_write_offset}] = ram_data_in;
            end
            if (model_closed)
            begin
                model_write_slot   = model_write_slot + slot_t'(1);
                model_write_offset = '0;
            end
            else if (write_enable)
            begin
                model_write_offset = model_write_offset + offset_t'(1);
            end
            if (model_released)
            begin
                model_read_slot   = model_read_slot + slot_t'(1);
                model_read_offset = '0;
            end
            else if (read_enable)
            begin
                model_read_offset = model_read_offset + offset_t'(1);
            end
            model_count = model_count + int'(model_closed) - int'(model_released);
        end
    end

    always @(negedge clock)
    begin
        if (!reset)
        begin
            check_value("pkt_waiting", 32'(pkt_waiting), 32'(model_count != 0));
            check_value("have_space", 32'(have_space), 32'(model_count < slot_count));
            if (read_pending)
            begin
                check_value("ram_data_out", 32'(ram_data_out), 32'(expected_data));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A short packet closes on its last word, or one cycle later without a word.
    task automatic write_packet(input int len, input bit separate_close);
        int i;
        @(posedge clock);
        while (!have_space)
            @(posedge clock);
        lengths.push_back(len);
        for (i = 0; i < len; i++)
        begin
            write_enable <= 1'b1;
            ram_data_in  <= data_t'($random(seed));
            pkt_complete <= (i == len - 1) && (len < slot_words) && !separate_close;
            @(posedge clock);
        end
        write_enable <= 1'b0;
        pkt_complete <= (len < slot_words) && separate_close;
        if ((len < slot_words) && separate_close)
        begin
            @(posedge clock);
            pkt_complete <= 1'b0;
        end
    endtask

    // Reads up to limit words of the oldest packet, then drops what is left.
    task automatic read_packet(input int limit, input bit skip_with_last);
        int len;
        int count;
        int i;
        bit needs_skip;
        @(posedge clock);
        while (!pkt_waiting)
            @(posedge clock);
        if (lengths.size() == 0)
        begin
            $display("Error: a packet is waiting but none was written.");
            $display("** FAIL **");
            $fatal(1, "Unexpected packet.");
        end
        len = lengths.pop_front();
        count = (limit < len) ? limit : len;
        for (i = 0; i < count; i++)
        begin
            read_enable <= 1'b1;
            skip_packet <= skip_with_last && (i == count - 1) && (count < slot_words);
            @(posedge clock);
        end
        needs_skip = (count < slot_words) && !(skip_with_last && count > 0);
        read_enable <= 1'b0;
        skip_packet <= needs_skip;
        if (needs_skip)
        begin
            @(posedge clock);
            skip_packet <= 1'b0;
        end
    endtask

    initial
    begin
        int n;
        int m;
        clock        = 1'b0;
        reset        = 1'b1;
        ram_data_in  = '0;
        write_enable = 1'b0;
        pkt_complete = 1'b0;
        read_enable  = 1'b0;
        skip_packet  = 1'b0;
        seed         = 32'hc9dc7e29;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        $display("Reset state");
        repeat (10) @(posedge clock);

        $display("Full packet round trip");
        write_packet(slot_words, 1'b0);
        read_packet(slot_words, 1'b0);

        $display("Short packets");
        for (n = 0; n < 3; n++)
        begin
            write_packet(short_length(), n[0]);
            read_packet(slot_words, 1'b0);
        end

        $display("Full and space flags");
        write_packet(slot_words, 1'b0);
        write_packet(37, 1'b0);
        write_packet(slot_words, 1'b1);
        write_packet(120, 1'b0);
        @(negedge clock);
        check_value("have_space", 32'(have_space), 32'(0));
        read_packet(slot_words, 1'b0);
        @(negedge clock);
        check_value("have_space", 32'(have_space), 32'(1));
        check_value("pkt_waiting", 32'(pkt_waiting), 32'(1));
        for (n = 0; n < 3; n++)
        begin
            read_packet(slot_words, 1'b0);
        end

        $display("Discarding a packet");
        write_packet(150, 1'b0);
        write_packet(slot_words, 1'b0);
        write_packet(90, 1'b0);
        read_packet(40, 1'b0);
        read_packet(0, 1'b0);
        read_packet(slot_words, 1'b0);

        // The last write closes and the last read releases on the same edge.
        $display("Close and release together");
        write_packet(50, 1'b0);
        fork
            write_packet(30, 1'b0);
            read_packet(30, 1'b1);
        join
        fork
            begin
                for (n = 0; n < 10; n++)
                begin
                    write_packet(pick_length(), 1'b0);
                end
            end
            begin
                for (m = 0; m < 11; m++)
                begin
                    read_packet(slot_words, m[0]);
                end
            end
        join

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/packet_fifo_pkg.sv
rtl/packet_write_port.sv
rtl/packet_read_port.sv
rtl/packet_slot_tracker.sv
rtl/packet_ram.sv
rtl/data_packet_fifo.sv
dv/tb_data_packet_fifo.sv

// ==== Makefile ====
# Verilator build and run for the packet FIFO testbench.

VERILATOR := verilator
FLAGS     := --binary --timing
LINT      := --lint-only --timing
TOP       := tb_data_packet_fifo
FILE_LIST := tb.f
OBJ_DIR   := obj_dir
PASS_TEXT := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The run passes only if the pass message shows up in the output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
